//--- rgb_spi.f
+incdir+verilog
verilog/rgb_pkg.sv
verilog/spi_pkg.sv
verilog/sync_sig.sv
verilog/spi_iff.sv
verilog/spi_decoder.sv
verilog/rgb_first_pixel.sv
verilog/rgb_spi_top.sv
testbench/tb_rgb_spi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rgb_spi testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_rgb_spi \
    -f rgb_spi.f

# The log decides the result, so the run status does not stop the script here
./obj_dir/Vtb_rgb_spi 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi

//--- testbench/tb_rgb_spi.sv
`timescale 1ns/100ps
`include "rgb_spi_macros.svh"

module tb_rgb_spi;

    // Clk cycles per sclk level
    localparam int SCLK_HALF_CYCLES = 8;
    // Covers ss sync, valid pipeline and decoder update
    localparam int SETTLE_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = 120000;
    // Opcodes outside the command set
    localparam logic [7:0] OP_DUMP = 8'hA5;
    localparam logic [7:0] OP_UNKNOWN = 8'h7E;

    logic                 clk;
    logic                 nrst;
    logic                 rgb_hsync;
    logic                 rgb_vsync;
    rgb_pkg::pixel_t      rgb_d;
    logic                 som_sclk;
    logic                 som_cs;
    logic                 som_mosi;
    logic                 som_miso;
    spi_pkg::rotation_t   rotation_data;
    spi_pkg::config_t     driver_conf;
    logic                 driver_new_conf_available;
    logic                 rgb_enable;

    // Host transaction buffers, byte 0 goes out first
    logic [7:0]           tx_bytes [8];
    logic [7:0]           rx_bytes [8];
    int                   tx_len;

    // Reference model state
    spi_pkg::rotation_t   m_rotation;
    spi_pkg::config_t     m_config;
    logic                 m_enable;
    rgb_pkg::debug_word_t m_debug;
    spi_pkg::reply_t      m_reply;
    int                   m_conf_writes;

    int                   conf_pulses;
    int                   cycle_count;

    rgb_spi_top dut_i (
        .clk                       (clk),
        .nrst                      (nrst),
        .rgb_hsync                 (rgb_hsync),
        .rgb_vsync                 (rgb_vsync),
        .rgb_d                     (rgb_d),
        .som_sclk                  (som_sclk),
        .som_cs                    (som_cs),
        .som_mosi                  (som_mosi),
        .som_miso                  (som_miso),
        .rotation_data             (rotation_data),
        .driver_conf               (driver_conf),
        .driver_new_conf_available (driver_new_conf_available),
        .rgb_enable                (rgb_enable)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Count configuration strobes seen on the port
    always @(posedge clk) begin
        if (nrst && driver_new_conf_available) begin
            conf_pulses <= conf_pulses + 1;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test sequence did not end within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Advance n cycles, land just after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t signal=%s actual=%0h expected=%0h",
                     $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Opcode plus random data bytes
    task automatic load_cmd(input logic [7:0] op, input int len);
        tx_len = len;
        tx_bytes[0] = op;
        for (int i = 1; i < 8; i++) begin
            tx_bytes[i] = 8'($urandom);
        end
    endtask

    // Mode 0 host, mosi set while sclk low, miso sampled before each rise
    task automatic spi_xfer();
        logic [7:0] rx;
        rx = 8'h00;
        som_cs = 1'b0;
        for (int b = 0; b < tx_len; b++) begin
            for (int i = 7; i >= 0; i--) begin
                som_mosi = tx_bytes[b][i];
                step(SCLK_HALF_CYCLES);
                rx = {rx[6:0], som_miso};
                som_sclk = 1'b1;
                step(SCLK_HALF_CYCLES);
                som_sclk = 1'b0;
            end
            rx_bytes[b] = rx;
        end
        step(SCLK_HALF_CYCLES);
        som_cs = 1'b1;
        step(SETTLE_CYCLES);
    endtask

    // Decoder rules applied to the command in tx_bytes
    task automatic apply_model();
        int len;
        len = (tx_len > `RGB_SPI_CMD_BYTES) ? `RGB_SPI_CMD_BYTES : tx_len;
        case (tx_bytes[0])
            `RGB_SPI_OP_WRITE_ROTATION: begin
                if (len == 3) begin
                    m_rotation = {tx_bytes[1], tx_bytes[2]};
                end
            end
            `RGB_SPI_OP_WRITE_CONFIG: begin
                if (len == 7) begin
                    m_config = {tx_bytes[1], tx_bytes[2], tx_bytes[3],
                                tx_bytes[4], tx_bytes[5], tx_bytes[6]};
                    m_conf_writes++;
                end
            end
            `RGB_SPI_OP_WRITE_ENABLE: begin
                if (len == 2) begin
                    m_enable = tx_bytes[1][0];
                end
            end
            `RGB_SPI_OP_READ_DEBUG: begin
                if (len == 1) begin
                    m_reply = {m_debug, 16'h0000};
                end
            end
            `RGB_SPI_OP_READ_CONFIG: begin
                if (len == 1) begin
                    m_reply = m_config;
                end
            end
            `RGB_SPI_OP_READ_ROTATION: begin
                if (len == 1) begin
                    m_reply = {m_rotation, 32'h0000_0000};
                end
            end
            default: m_reply = '0;
        endcase
    endtask

    // One transaction, miso checked against the pending reply
    task automatic run_cmd();
        spi_pkg::reply_t exp_reply;
        logic [7:0]      exp_byte;
        exp_reply = m_reply;
        spi_xfer();
        for (int b = 0; b < tx_len; b++) begin
            // Past the reply the shifter only holds zeros
            exp_byte = (b < `RGB_SPI_REPLY_BYTES) ? exp_reply[47 - 8*b -: 8] : 8'h00;
            check($sformatf("som_miso byte %0d", b), 64'(rx_bytes[b]), 64'(exp_byte));
        end
        apply_model();
        check("rotation_data", 64'(rotation_data), 64'(m_rotation));
        check("driver_conf", 64'(driver_conf), 64'(m_config));
        check("rgb_enable", 64'(rgb_enable), 64'(m_enable));
        check("driver_new_conf_available", 64'(driver_new_conf_available), 64'h0);
        check("config pulse count", 64'(conf_pulses), 64'(m_conf_writes));
    endtask

    // Six bytes with an unknown opcode clock out the whole reply
    task automatic dump_reply();
        load_cmd(OP_DUMP, 6);
        run_cmd();
    endtask

    // First pixel held 3 cycles each side of the joint sync rise
    task automatic send_frame(input rgb_pkg::pixel_t first);
        rgb_d = first;
        step(3);
        rgb_hsync = 1'b1;
        rgb_vsync = 1'b1;
        step(3);
        rgb_d = 24'($urandom);
        step(4);
        rgb_hsync = 1'b0;
        step(4);
        // Later lines, vsync stays high
        for (int l = 0; l < 2; l++) begin
            rgb_d = 24'($urandom);
            step(3);
            rgb_hsync = 1'b1;
            step(6);
            rgb_hsync = 1'b0;
            step(4);
        end
        rgb_vsync = 1'b0;
        step(10);
        if (m_enable) begin
            m_debug = {8'h00, first};
        end
    endtask

    initial begin
        int         len;
        int         good;
        logic [7:0] op;
        void'($urandom(32'h9431));
        nrst = 1'b0;
        rgb_hsync = 1'b0;
        rgb_vsync = 1'b0;
        rgb_d = '0;
        som_sclk = 1'b0;
        som_cs = 1'b1;
        som_mosi = 1'b0;
        m_rotation = '0;
        m_config = '0;
        m_enable = 1'b0;
        m_debug = '0;
        m_reply = '0;
        m_conf_writes = 0;
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        step(2);

        // Reset state
        check("rotation_data", 64'(rotation_data), 64'h0);
        check("driver_conf", 64'(driver_conf), 64'h0);
        check("rgb_enable", 64'(rgb_enable), 64'h0);
        check("driver_new_conf_available", 64'(driver_new_conf_available), 64'h0);
        dump_reply();

        // Rotation write and echo
        for (int i = 0; i < 5; i++) begin
            load_cmd(`RGB_SPI_OP_WRITE_ROTATION, 3);
            run_cmd();
            load_cmd(`RGB_SPI_OP_READ_ROTATION, 1);
            run_cmd();
            dump_reply();
        end

        // Configuration write, strobe count and echo
        for (int i = 0; i < 5; i++) begin
            load_cmd(`RGB_SPI_OP_WRITE_CONFIG, 7);
            run_cmd();
            load_cmd(`RGB_SPI_OP_READ_CONFIG, 1);
            run_cmd();
            dump_reply();
        end

        // Writes with a wrong byte count
        for (int i = 0; i < 6; i++) begin
            case (i % 3)
                0: begin
                    op = `RGB_SPI_OP_WRITE_ROTATION;
                    good = 3;
                end
                1: begin
                    op = `RGB_SPI_OP_WRITE_CONFIG;
                    good = 7;
                end
                default: begin
                    op = `RGB_SPI_OP_WRITE_ENABLE;
                    good = 2;
                end
            endcase
            do begin
                len = int'($urandom % 7) + 1;
            end while (len == good);
            load_cmd(op, len);
            // Enable bit that would flip the register if accepted
            tx_bytes[1][0] = ~m_enable;
            run_cmd();
        end
        // Over long commands
        load_cmd(`RGB_SPI_OP_WRITE_ROTATION, 8);
        run_cmd();
        load_cmd(`RGB_SPI_OP_WRITE_ENABLE, 8);
        tx_bytes[1][0] = ~m_enable;
        run_cmd();
        // Unknown opcode wipes a pending reply
        load_cmd(`RGB_SPI_OP_READ_ROTATION, 1);
        run_cmd();
        load_cmd(OP_UNKNOWN, 1);
        run_cmd();
        dump_reply();

        // Frames with the capture path off and on in turn
        for (int i = 0; i < 6; i++) begin
            load_cmd(`RGB_SPI_OP_WRITE_ENABLE, 2);
            tx_bytes[1][0] = (i % 2 == 1);
            run_cmd();
            send_frame(24'($urandom));
            load_cmd(`RGB_SPI_OP_READ_DEBUG, 1);
            run_cmd();
            dump_reply();
        end

        check("config pulse count", 64'(conf_pulses), 64'(m_conf_writes));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- verilog/rgb_first_pixel.sv
`timescale 1ns/100ps

module rgb_first_pixel (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 rgb_hsync,
    input  logic                 rgb_vsync,
    input  logic                 rgb_enable,
    input  rgb_pkg::pixel_t      rgb_d,
    output rgb_pkg::debug_word_t debug_data
);

    // Video signals in clk
    logic            hsync;
    logic            vsync;
    rgb_pkg::pixel_t pixel;
    logic            last_hsync;
    logic            last_vsync;
    // Frame start seen while enabled
    logic            frame_start;
    // Pixel aligned with frame_start
    rgb_pkg::pixel_t pixel_d;

    sync_sig #(.SIZE(1)) sync_hsync_i (.clk(clk), .nrst(nrst), .in_sig(rgb_hsync), .out_sig(hsync));
    sync_sig #(.SIZE(1)) sync_vsync_i (.clk(clk), .nrst(nrst), .in_sig(rgb_vsync), .out_sig(vsync));
    sync_sig #(.SIZE(24)) sync_data_i (.clk(clk), .nrst(nrst), .in_sig(rgb_d), .out_sig(pixel));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_hsync  <= 1'b0;
            last_vsync  <= 1'b0;
            frame_start <= 1'b0;
            debug_data  <= '0;
        end else begin
            last_hsync <= hsync;
            last_vsync <= vsync;
            // Both syncs rising together marks the first pixel
            frame_start <= hsync & ~last_hsync & vsync & ~last_vsync & rgb_enable;
            if (frame_start) begin
                debug_data <= {8'h00, pixel_d};
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pixel_d <= '0;
        end else begin
            pixel_d <= pixel;
        end
    end

endmodule

//--- verilog/rgb_pkg.sv
package rgb_pkg;

    // One pixel of the parallel RGB bus
    // Red in the top byte, blue in the bottom byte
    typedef logic [23:0] pixel_t;

    // Readback word for the host
    // Top byte reserved, low 24 bits hold a captured pixel
    typedef logic [31:0] debug_word_t;

endpackage

//--- verilog/rgb_spi_macros.svh
`ifndef RGB_SPI_MACROS_SVH
`define RGB_SPI_MACROS_SVH

// Flops in every clock domain crossing
`define RGB_SPI_SYNC_STAGES 2

// Longest command kept, opcode byte included
`define RGB_SPI_CMD_BYTES 7

// Reply length shifted out on miso
`define RGB_SPI_REPLY_BYTES 6

// Write opcodes
`define RGB_SPI_OP_WRITE_ROTATION 8'h01
`define RGB_SPI_OP_WRITE_CONFIG   8'h02
`define RGB_SPI_OP_WRITE_ENABLE   8'h03

// Read request opcodes, answered in the next transaction
`define RGB_SPI_OP_READ_DEBUG     8'h10
`define RGB_SPI_OP_READ_CONFIG    8'h11
`define RGB_SPI_OP_READ_ROTATION  8'h12

`endif

//--- verilog/rgb_spi_top.sv
`timescale 1ns/100ps

module rgb_spi_top (
    input  logic               clk,
    input  logic               nrst,
    input  logic               rgb_hsync,
    input  logic               rgb_vsync,
    input  rgb_pkg::pixel_t    rgb_d,
    input  logic               som_sclk,
    input  logic               som_cs,
    input  logic               som_mosi,
    output logic               som_miso,
    output spi_pkg::rotation_t rotation_data,
    output spi_pkg::config_t   driver_conf,
    output logic               driver_new_conf_available,
    output logic               rgb_enable
);

    // Interface to decoder
    spi_pkg::cmd_buf_t    cmd_read;
    spi_pkg::byte_count_t cmd_len_bytes;
    spi_pkg::reply_t      cmd_write;
    logic                 cmd_valid;

    // Capture readback
    rgb_pkg::debug_word_t debug_data;

    spi_iff spi_iff_i (
        .clk           (clk),
        .nrst          (nrst),
        .spi_clk       (som_sclk),
        .spi_ss        (som_cs),
        .spi_mosi      (som_mosi),
        .spi_miso      (som_miso),
        .cmd_read      (cmd_read),
        .cmd_len_bytes (cmd_len_bytes),
        .cmd_write     (cmd_write),
        .valid         (cmd_valid)
    );

    spi_decoder spi_decoder_i (
        .clk                  (clk),
        .nrst                 (nrst),
        .valid                (cmd_valid),
        .cmd_read             (cmd_read),
        .cmd_len_bytes        (cmd_len_bytes),
        .cmd_write            (cmd_write),
        .rotation_data        (rotation_data),
        .configuration        (driver_conf),
        .new_config_available (driver_new_conf_available),
        .rgb_enable           (rgb_enable),
        .debug_data           (debug_data)
    );

    // First pixel of each frame into the debug word
    rgb_first_pixel rgb_first_pixel_i (
        .clk        (clk),
        .nrst       (nrst),
        .rgb_hsync  (rgb_hsync),
        .rgb_vsync  (rgb_vsync),
        .rgb_enable (rgb_enable),
        .rgb_d      (rgb_d),
        .debug_data (debug_data)
    );

endmodule

//--- verilog/spi_decoder.sv
`timescale 1ns/100ps

module spi_decoder (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  valid,
    input  spi_pkg::cmd_buf_t     cmd_read,
    input  spi_pkg::byte_count_t  cmd_len_bytes,
    output spi_pkg::reply_t       cmd_write,
    output spi_pkg::rotation_t    rotation_data,
    output spi_pkg::config_t      configuration,
    output logic                  new_config_available,
    output logic                  rgb_enable,
    input  rgb_pkg::debug_word_t  debug_data
);

    // Command lengths, opcode byte included
    localparam spi_pkg::byte_count_t LEN_ROTATION = 3'd3;
    localparam spi_pkg::byte_count_t LEN_CONFIG   = 3'd7;
    localparam spi_pkg::byte_count_t LEN_ENABLE   = 3'd2;
    localparam spi_pkg::byte_count_t LEN_READ     = 3'd1;

    localparam int CMD_MSB = $bits(spi_pkg::cmd_buf_t) - 1;

    spi_pkg::spi_opcode_t opcode;

    // Opcode is always the first byte
    assign opcode = spi_pkg::spi_opcode_t'(cmd_read[CMD_MSB -: 8]);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_write            <= '0;
            rotation_data        <= '0;
            configuration        <= '0;
            new_config_available <= 1'b0;
            rgb_enable           <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            new_config_available <= 1'b0;
            if (valid) begin
                case (opcode)
                    spi_pkg::WRITE_ROTATION: begin
                        if (cmd_len_bytes == LEN_ROTATION) begin
                            rotation_data <= cmd_read[CMD_MSB-8 -: 16];
                        end
                    end
                    spi_pkg::WRITE_CONFIG: begin
                        if (cmd_len_bytes == LEN_CONFIG) begin
                            configuration        <= cmd_read[CMD_MSB-8 -: 48];
                            new_config_available <= 1'b1;
                        end
                    end
                    spi_pkg::WRITE_ENABLE: begin
                        // Only bit 0 of the data byte matters
                        if (cmd_len_bytes == LEN_ENABLE) begin
                            rgb_enable <= cmd_read[CMD_MSB-15];
                        end
                    end
                    spi_pkg::READ_DEBUG: begin
                        if (cmd_len_bytes == LEN_READ) begin
                            cmd_write <= {debug_data, 16'h0000};
                        end
                    end
                    spi_pkg::READ_CONFIG: begin
                        if (cmd_len_bytes == LEN_READ) begin
                            cmd_write <= configuration;
                        end
                    end
                    spi_pkg::READ_ROTATION: begin
                        if (cmd_len_bytes == LEN_READ) begin
                            cmd_write <= {rotation_data, 32'h0000_0000};
                        end
                    end
                    // Unknown opcode clears the pending reply
                    default: cmd_write <= '0;
                endcase
            end
        end
    end

    a_conf_pulse: assert property (@(posedge clk) disable iff (!nrst)
        new_config_available |=> !new_config_available);

endmodule

//--- verilog/spi_iff.sv
`timescale 1ns/100ps
`include "rgb_spi_macros.svh"

module spi_iff (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 spi_clk,
    input  logic                 spi_ss,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    output spi_pkg::cmd_buf_t    cmd_read,
    output spi_pkg::byte_count_t cmd_len_bytes,
    input  spi_pkg::reply_t      cmd_write,
    output logic                 valid
);

    // Index of the top byte slot in the command buffer
    localparam int CMD_TOP = `RGB_SPI_CMD_BYTES - 1;
    localparam int REPLY_MSB = $bits(spi_pkg::reply_t) - 1;

    // SPI pins brought into clk
    logic sclk_s;
    logic ss_s;
    logic mosi_s;
    logic sclk_prev;
    logic ss_prev;
    logic sclk_rise;
    logic sclk_fall;
    logic ss_rise;
    logic ss_fall;

    spi_pkg::spi_state_t  state;
    spi_pkg::cmd_buf_t    cmd_buf;
    spi_pkg::byte_count_t byte_cnt;
    spi_pkg::reply_t      reply_sr;
    logic [2:0]           bit_cnt;
    logic [6:0]           rx_bits;
    // Delay from end of transaction to valid
    logic [2:0]           end_pipe;

    sync_sig #(.SIZE(1)) sync_sclk_i (.clk(clk), .nrst(nrst), .in_sig(spi_clk), .out_sig(sclk_s));
    sync_sig #(.SIZE(1)) sync_ss_i (.clk(clk), .nrst(nrst), .in_sig(spi_ss), .out_sig(ss_s));
    sync_sig #(.SIZE(1)) sync_mosi_i (.clk(clk), .nrst(nrst), .in_sig(spi_mosi), .out_sig(mosi_s));

    // Edge detection on the oversampled pins
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sclk_prev <= 1'b0;
            ss_prev   <= 1'b0;
        end else begin
            sclk_prev <= sclk_s;
            ss_prev   <= ss_s;
        end
    end

    assign sclk_rise = sclk_s & ~sclk_prev;
    assign sclk_fall = ~sclk_s & sclk_prev;
    assign ss_rise   = ss_s & ~ss_prev;
    assign ss_fall   = ~ss_s & ss_prev;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= spi_pkg::IDLE;
            cmd_buf  <= '0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            rx_bits  <= '0;
            reply_sr <= '0;
            end_pipe <= '0;
        end else begin
            end_pipe <= {end_pipe[1:0], 1'b0};
            case (state)
                spi_pkg::IDLE: begin
                    // Chip select asserted, take the pending reply
                    if (ss_fall) begin
                        state    <= spi_pkg::SHIFT;
                        reply_sr <= cmd_write;
                        cmd_buf  <= '0;
                        byte_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (ss_rise) begin
                        state       <= spi_pkg::IDLE;
                        end_pipe[0] <= 1'b1;
                    end else begin
                        // Mode 0, mosi sampled on rising sclk
                        if (sclk_rise) begin
                            rx_bits <= {rx_bits[5:0], mosi_s};
                            bit_cnt <= bit_cnt + 3'd1;
                            // Whole byte, store it unless the buffer is full
                            if (bit_cnt == 3'd7 && int'(byte_cnt) < `RGB_SPI_CMD_BYTES) begin
                                cmd_buf[(CMD_TOP - int'(byte_cnt))*8 +: 8] <= {rx_bits, mosi_s};
                                byte_cnt <= byte_cnt + 3'd1;
                            end
                        end
                        // Next reply bit after falling sclk
                        if (sclk_fall) begin
                            reply_sr <= {reply_sr[REPLY_MSB-1:0], 1'b0};
                        end
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

    // Command outputs hold until the next transaction ends
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid         <= 1'b0;
            cmd_read      <= '0;
            cmd_len_bytes <= '0;
        end else begin
            valid <= end_pipe[2];
            if (end_pipe[2]) begin
                cmd_read      <= cmd_buf;
                cmd_len_bytes <= byte_cnt;
            end
        end
    end

    // Reply MSB drives miso only while selected
    assign spi_miso = (state == spi_pkg::SHIFT) && reply_sr[REPLY_MSB];

    a_valid_idle: assert property (@(posedge clk) disable iff (!nrst)
        valid |-> state == spi_pkg::IDLE);

    // Byte count sticks at a full buffer for the rest of the transaction
    a_len_max: assert property (@(posedge clk) disable iff (!nrst)
        (state == spi_pkg::SHIFT && int'(byte_cnt) == `RGB_SPI_CMD_BYTES)
        |=> int'(byte_cnt) == `RGB_SPI_CMD_BYTES);

endmodule

//--- verilog/spi_pkg.sv
`include "rgb_spi_macros.svh"

package spi_pkg;

    // Received command, first byte in the top 8 bits
    typedef logic [`RGB_SPI_CMD_BYTES*8-1:0] cmd_buf_t;

    // Number of whole bytes in a command
    typedef logic [2:0] byte_count_t;

    // Reply register, MSB goes out first
    typedef logic [`RGB_SPI_REPLY_BYTES*8-1:0] reply_t;

    // Payloads held by the decoder
    typedef logic [47:0] config_t;
    typedef logic [15:0] rotation_t;

    // Opcodes, first byte of every command
    typedef enum logic [7:0] {
        WRITE_ROTATION = `RGB_SPI_OP_WRITE_ROTATION,
        WRITE_CONFIG   = `RGB_SPI_OP_WRITE_CONFIG,
        WRITE_ENABLE   = `RGB_SPI_OP_WRITE_ENABLE,
        READ_DEBUG     = `RGB_SPI_OP_READ_DEBUG,
        READ_CONFIG    = `RGB_SPI_OP_READ_CONFIG,
        READ_ROTATION  = `RGB_SPI_OP_READ_ROTATION
    } spi_opcode_t;

    // Slave interface FSM
    typedef enum logic {IDLE, SHIFT} spi_state_t;

endpackage

//--- verilog/sync_sig.sv
`timescale 1ns/100ps
`include "rgb_spi_macros.svh"

module sync_sig #(
    parameter int SIZE = 1
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic [SIZE-1:0] in_sig,
    output logic [SIZE-1:0] out_sig
);

    // Flop chain, stage 0 takes the asynchronous input
    logic [SIZE-1:0] stage [`RGB_SPI_SYNC_STAGES];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `RGB_SPI_SYNC_STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in_sig;
            for (int i = 1; i < `RGB_SPI_SYNC_STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Last stage is safe to use in clk
    assign out_sig = stage[`RGB_SPI_SYNC_STAGES-1];

endmodule
